// ==== logic/id_pkg.sv ====
// Field positions assume uncompressed 32-bit RV32I words; no M, A, C or CSR encodings exist here
package id_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned XLEN = 32;
  localparam int unsigned NUM_RF_PORTS = 2;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      rf_addr_t;
  typedef logic [6:0]      opcode_t;
  // 0 byte, 1 half, 2 word
  typedef logic [1:0]      lsu_size_t;

  ////////////////////
  // Instruction fields
  ////////////////////

  // Register index positions, width from rf_addr_t
  localparam int unsigned REG_S1_LSB = 15;
  localparam int unsigned REG_S2_LSB = 20;
  localparam int unsigned REG_D_LSB  = 7;

  // Major opcodes of the supported RV32I subset
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OPIMM  = 7'b0010011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;

  ////////////////////
  // Decode enums
  ////////////////////

  // Arithmetic first, then the branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {FWD_RF, FWD_EX, FWD_WB} fwd_sel_e;

  typedef enum logic [1:0] {OPS_REG, OPS_PC, OPS_IMM, OPS_ZERO} op_src_e;

  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_PCINCR} imm_sel_e;

  typedef enum logic [1:0] {OPC_STORE_DATA, OPC_BRANCH_TGT, OPC_NONE} opc_sel_e;

  typedef enum logic {JT_JAL, JT_JALR} jt_sel_e;

endpackage

// ==== logic/id_decoder.sv ====
// RV32I base only; SYSTEM, FENCE and every extension opcode decode as illegal with all units off
`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
  input  word_t     instr_i,
  output logic      alu_en_o,
  output alu_op_e   alu_op_o,
  output logic      lsu_en_o,
  output logic      lsu_we_o,
  output logic      lsu_sext_o,
  output lsu_size_t lsu_size_o,
  output op_src_e   src_sel_o [NUM_RF_PORTS],
  output imm_sel_e  imm_sel_o,
  output opc_sel_e  opc_sel_o,
  output jt_sel_e   jt_sel_o,
  output logic      branch_o,
  output logic      rf_we_o,
  output rf_addr_t  rd_o,
  output logic      illegal_o
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  // Write intent before the rd == x0 and illegal qualifiers
  logic       rf_we_raw;

  // funct3 to operator for OP and OP-IMM, alt picks SUB or SRA
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    arith_op = alt ? ALU_SUB : ALU_ADD;
      3'd1:    arith_op = ALU_SLL;
      3'd2:    arith_op = ALU_SLT;
      3'd3:    arith_op = ALU_SLTU;
      3'd4:    arith_op = ALU_XOR;
      3'd5:    arith_op = alt ? ALU_SRA : ALU_SRL;
      3'd6:    arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  endfunction

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd_o   = instr_i[REG_D_LSB +: $bits(rf_addr_t)];

  always_comb begin
    // Defaults describe a register-register ALU op with nothing enabled
    alu_en_o     = 1'b0;
    alu_op_o     = ALU_ADD;
    lsu_en_o     = 1'b0;
    lsu_we_o     = 1'b0;
    lsu_sext_o   = 1'b0;
    lsu_size_o   = 2'd2;
    src_sel_o[0] = OPS_REG;
    src_sel_o[1] = OPS_REG;
    imm_sel_o    = IMM_I;
    opc_sel_o    = OPC_NONE;
    jt_sel_o     = JT_JAL;
    branch_o     = 1'b0;
    rf_we_raw    = 1'b0;
    illegal_o    = 1'b0;

    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        // LUI adds the U immediate to zero, AUIPC to the PC
        alu_en_o     = 1'b1;
        rf_we_raw    = 1'b1;
        src_sel_o[0] = (opcode == OPC_LUI) ? OPS_ZERO : OPS_PC;
        src_sel_o[1] = OPS_IMM;
        imm_sel_o    = IMM_U;
      end
      OPC_JAL, OPC_JALR: begin
        // Link value is PC + 4 through the ALU
        alu_en_o     = 1'b1;
        rf_we_raw    = 1'b1;
        src_sel_o[0] = OPS_PC;
        src_sel_o[1] = OPS_IMM;
        imm_sel_o    = IMM_PCINCR;
        jt_sel_o     = (opcode == OPC_JALR) ? JT_JALR : JT_JAL;
        illegal_o    = (opcode == OPC_JALR) && (funct3 != 3'd0);
      end
      OPC_BRANCH: begin
        alu_en_o  = 1'b1;
        branch_o  = 1'b1;
        opc_sel_o = OPC_BRANCH_TGT;
        case (funct3)
          3'd0:    alu_op_o = ALU_EQ;
          3'd1:    alu_op_o = ALU_NE;
          3'd4:    alu_op_o = ALU_LT;
          3'd5:    alu_op_o = ALU_GE;
          3'd6:    alu_op_o = ALU_LTU;
          3'd7:    alu_op_o = ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        // Address is rs1 + I immediate
        alu_en_o     = 1'b1;
        lsu_en_o     = 1'b1;
        rf_we_raw    = 1'b1;
        src_sel_o[1] = OPS_IMM;
        lsu_size_o   = funct3[1:0];
        lsu_sext_o   = !funct3[2];
        illegal_o    = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        alu_en_o     = 1'b1;
        lsu_en_o     = 1'b1;
        lsu_we_o     = 1'b1;
        src_sel_o[1] = OPS_IMM;
        imm_sel_o    = IMM_S;
        opc_sel_o    = OPC_STORE_DATA;
        lsu_size_o   = funct3[1:0];
        illegal_o    = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_OPIMM: begin
        alu_en_o     = 1'b1;
        rf_we_raw    = 1'b1;
        src_sel_o[1] = OPS_IMM;
        // ADDI has no SUB form, only SRAI reads bit 30
        alu_op_o     = arith_op(funct3, (funct3 == 3'd5) && funct7[5]);
        illegal_o    = ((funct3 == 3'd1) && (funct7 != 7'h00)) ||
                       ((funct3 == 3'd5) && (funct7 != 7'h00) && (funct7 != 7'h20));
      end
      OPC_OP: begin
        alu_en_o  = 1'b1;
        rf_we_raw = 1'b1;
        alu_op_o  = arith_op(funct3, funct7[5]);
        illegal_o = !((funct7 == 7'h00) ||
                      ((funct7 == 7'h20) && ((funct3 == 3'd0) || (funct3 == 3'd5))));
      end
      default: illegal_o = 1'b1;
    endcase

    // Illegal words must not reach any unit
    if (illegal_o) begin
      alu_en_o  = 1'b0;
      lsu_en_o  = 1'b0;
      lsu_we_o  = 1'b0;
      branch_o  = 1'b0;
      rf_we_raw = 1'b0;
    end
    // x0 is never written
    rf_we_o = rf_we_raw && (rd_o != '0);
  end

endmodule

// ==== logic/id_imm_target.sv ====
// PC increment fixed at 4 since compressed words are not supported; JALR base must arrive forwarded
`timescale 1ns/1ps

module id_imm_target import id_pkg::*; (
  input  word_t    instr_i,
  input  word_t    pc_i,
  input  imm_sel_e imm_sel_i,
  input  jt_sel_e  jt_sel_i,
  input  word_t    jalr_base_i,
  output word_t    imm_o,
  output word_t    bch_target_o,
  output word_t    jmp_target_o
);

  word_t imm_i_type;
  word_t imm_s_type;
  word_t imm_b_type;
  word_t imm_u_type;
  word_t imm_j_type;
  word_t jalr_sum;

  // Sign extension from bit 31 in every signed format
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb begin
    case (imm_sel_i)
      IMM_S:      imm_o = imm_s_type;
      IMM_U:      imm_o = imm_u_type;
      IMM_PCINCR: imm_o = 32'd4;
      default:    imm_o = imm_i_type;
    endcase
  end

  // Conditional branch target travels to EX as operand C
  assign bch_target_o = pc_i + imm_b_type;

  // JALR drops bit 0 of the sum
  assign jalr_sum     = jalr_base_i + imm_i_type;
  assign jmp_target_o = (jt_sel_i == JT_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                              : pc_i + imm_j_type;

endmodule

// ==== logic/id_operand_lane.sv ====
// Forwarding select is taken as given by the controller; an unused encoding reads the register file
`timescale 1ns/1ps

module id_operand_lane import id_pkg::*; (
  input  word_t    rf_rdata_i,
  input  word_t    wdata_ex_i,
  input  word_t    wdata_wb_i,
  input  fwd_sel_e fwd_sel_i,
  input  op_src_e  src_sel_i,
  input  word_t    pc_i,
  input  word_t    imm_i,
  output word_t    fwd_o,
  output word_t    operand_o
);

  ////////////////////
  // Forwarding
  ////////////////////

  // EX result is newer than WB, controller resolves priority
  always_comb begin
    case (fwd_sel_i)
      FWD_EX:  fwd_o = wdata_ex_i;
      FWD_WB:  fwd_o = wdata_wb_i;
      default: fwd_o = rf_rdata_i;
    endcase
  end

  ////////////////////
  // Operand source
  ////////////////////

  // Register path always goes through the forwarding result
  always_comb begin
    case (src_sel_i)
      OPS_PC:   operand_o = pc_i;
      OPS_IMM:  operand_o = imm_i;
      OPS_ZERO: operand_o = '0;
      default:  operand_o = fwd_o;
    endcase
  end

endmodule

// ==== logic/id_ex_pipe_reg.sv ====
// A bubble only clears ex_valid_o; other ex_* fields keep old values and are qualified by valid
`timescale 1ns/1ps

module id_ex_pipe_reg import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      id_valid_i,
  input  logic      ex_ready_i,
  input  logic      alu_en_i,
  input  alu_op_e   alu_op_i,
  input  logic      lsu_en_i,
  input  logic      lsu_we_i,
  input  logic      lsu_sext_i,
  input  lsu_size_t lsu_size_i,
  input  logic      rf_we_i,
  input  rf_addr_t  rd_i,
  input  logic      illegal_i,
  input  logic      branch_i,
  input  word_t     operand_a_i,
  input  word_t     operand_b_i,
  input  word_t     store_data_i,
  input  word_t     bch_target_i,
  input  word_t     pc_i,
  input  opc_sel_e  opc_sel_i,
  output logic      ex_valid_o,
  output logic      ex_alu_en_o,
  output alu_op_e   ex_alu_op_o,
  output word_t     ex_operand_a_o,
  output word_t     ex_operand_b_o,
  output word_t     ex_operand_c_o,
  output logic      ex_lsu_en_o,
  output logic      ex_lsu_we_o,
  output logic      ex_lsu_sext_o,
  output lsu_size_t ex_lsu_size_o,
  output logic      ex_rf_we_o,
  output rf_addr_t  ex_rd_o,
  output logic      ex_illegal_o,
  output logic      ex_branch_o,
  output word_t     ex_pc_o
);

  word_t operand_c;

  // Store data or branch target share the third operand
  always_comb begin
    case (opc_sel_i)
      OPC_STORE_DATA: operand_c = store_data_i;
      OPC_BRANCH_TGT: operand_c = bch_target_i;
      default:        operand_c = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o     <= 1'b0;
      ex_alu_en_o    <= 1'b0;
      ex_alu_op_o    <= ALU_ADD;
      ex_operand_a_o <= '0;
      ex_operand_b_o <= '0;
      ex_operand_c_o <= '0;
      ex_lsu_en_o    <= 1'b0;
      ex_lsu_we_o    <= 1'b0;
      ex_lsu_sext_o  <= 1'b0;
      ex_lsu_size_o  <= '0;
      ex_rf_we_o     <= 1'b0;
      ex_rd_o        <= '0;
      ex_illegal_o   <= 1'b0;
      ex_branch_o    <= 1'b0;
      ex_pc_o        <= '0;
    end else if (id_valid_i && ex_ready_i) begin
      ex_valid_o   <= 1'b1;
      ex_alu_en_o  <= alu_en_i;
      ex_lsu_en_o  <= lsu_en_i;
      ex_rf_we_o   <= rf_we_i;
      ex_illegal_o <= illegal_i;
      ex_branch_o  <= branch_i;
      ex_pc_o      <= pc_i;
      // Operand flops only toggle for units that use them
      if (alu_en_i || lsu_en_i) begin
        ex_alu_op_o    <= alu_op_i;
        ex_operand_a_o <= operand_a_i;
        ex_operand_b_o <= operand_b_i;
        ex_operand_c_o <= operand_c;
      end
      if (lsu_en_i) begin
        ex_lsu_we_o   <= lsu_we_i;
        ex_lsu_sext_o <= lsu_sext_i;
        ex_lsu_size_o <= lsu_size_i;
      end
      if (rf_we_i) begin
        ex_rd_o <= rd_i;
      end
    end else if (ex_ready_i) begin
      // EX takes a bubble
      ex_valid_o <= 1'b0;
    end
  end

  // EX stall freezes the whole register
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable({ex_valid_o, ex_alu_en_o, ex_alu_op_o, ex_operand_a_o,
                             ex_operand_b_o, ex_operand_c_o, ex_lsu_en_o, ex_lsu_we_o,
                             ex_lsu_sext_o, ex_lsu_size_o, ex_rf_we_o, ex_rd_o,
                             ex_illegal_o, ex_branch_o, ex_pc_o}));

endmodule

// ==== logic/id_stage.sv ====
// NUM_RF_PORTS must stay 2; lane 0 is operand A and JALR base, lane 1 is operand B and store data
`timescale 1ns/1ps

module id_stage import id_pkg::*; #(
  parameter int unsigned NUM_RF_PORTS = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      instr_valid_i,
  input  word_t     instr_i,
  input  word_t     pc_i,
  input  word_t     rf_rdata_i [NUM_RF_PORTS],
  input  fwd_sel_e  fwd_sel_i [NUM_RF_PORTS],
  input  word_t     rf_wdata_ex_i,
  input  word_t     rf_wdata_wb_i,
  input  logic      kill_id_i,
  input  logic      halt_id_i,
  input  logic      ex_ready_i,
  output logic      id_ready_o,
  output rf_addr_t  rf_raddr_o [NUM_RF_PORTS],
  output word_t     jmp_target_o,
  output logic      ex_valid_o,
  output logic      ex_alu_en_o,
  output alu_op_e   ex_alu_op_o,
  output word_t     ex_operand_a_o,
  output word_t     ex_operand_b_o,
  output word_t     ex_operand_c_o,
  output logic      ex_lsu_en_o,
  output logic      ex_lsu_we_o,
  output logic      ex_lsu_sext_o,
  output lsu_size_t ex_lsu_size_o,
  output logic      ex_rf_we_o,
  output rf_addr_t  ex_rd_o,
  output logic      ex_illegal_o,
  output logic      ex_branch_o,
  output word_t     ex_pc_o
);

  // Decoder outputs
  logic      alu_en;
  alu_op_e   alu_op;
  logic      lsu_en;
  logic      lsu_we;
  logic      lsu_sext;
  lsu_size_t lsu_size;
  op_src_e   src_sel [NUM_RF_PORTS];
  imm_sel_e  imm_sel;
  opc_sel_e  opc_sel;
  jt_sel_e   jt_sel;
  logic      branch;
  logic      rf_we;
  rf_addr_t  rd;
  logic      illegal;
  // Immediate and target path
  word_t     imm;
  word_t     bch_target;
  // Per lane results
  word_t     fwd [NUM_RF_PORTS];
  word_t     operand [NUM_RF_PORTS];
  logic      id_valid;

  ////////////////////
  // Handshake
  ////////////////////

  // Kill empties ID so it stays ready, halt blocks it
  assign id_valid   = instr_valid_i && !kill_id_i && !halt_id_i;
  assign id_ready_o = kill_id_i || (ex_ready_i && !halt_id_i);

  // Register file read addresses
  assign rf_raddr_o[0] = instr_i[REG_S1_LSB +: $bits(rf_addr_t)];
  assign rf_raddr_o[1] = instr_i[REG_S2_LSB +: $bits(rf_addr_t)];

  ////////////////////
  // Decode datapath
  ////////////////////

  id_decoder u_decoder (
    .instr_i    (instr_i),
    .alu_en_o   (alu_en),
    .alu_op_o   (alu_op),
    .lsu_en_o   (lsu_en),
    .lsu_we_o   (lsu_we),
    .lsu_sext_o (lsu_sext),
    .lsu_size_o (lsu_size),
    .src_sel_o  (src_sel),
    .imm_sel_o  (imm_sel),
    .opc_sel_o  (opc_sel),
    .jt_sel_o   (jt_sel),
    .branch_o   (branch),
    .rf_we_o    (rf_we),
    .rd_o       (rd),
    .illegal_o  (illegal)
  );

  // JALR base takes the forwarded rs1 from lane 0
  id_imm_target u_imm_target (
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .imm_sel_i    (imm_sel),
    .jt_sel_i     (jt_sel),
    .jalr_base_i  (fwd[0]),
    .imm_o        (imm),
    .bch_target_o (bch_target),
    .jmp_target_o (jmp_target_o)
  );

  for (genvar g = 0; g < NUM_RF_PORTS; g++) begin : g_lane
    id_operand_lane u_lane (
      .rf_rdata_i (rf_rdata_i[g]),
      .wdata_ex_i (rf_wdata_ex_i),
      .wdata_wb_i (rf_wdata_wb_i),
      .fwd_sel_i  (fwd_sel_i[g]),
      .src_sel_i  (src_sel[g]),
      .pc_i       (pc_i),
      .imm_i      (imm),
      .fwd_o      (fwd[g]),
      .operand_o  (operand[g])
    );
  end

  // Store data is the forwarded rs2 from lane 1
  id_ex_pipe_reg u_id_ex_pipe_reg (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_valid_i     (id_valid),
    .ex_ready_i     (ex_ready_i),
    .alu_en_i       (alu_en),
    .alu_op_i       (alu_op),
    .lsu_en_i       (lsu_en),
    .lsu_we_i       (lsu_we),
    .lsu_sext_i     (lsu_sext),
    .lsu_size_i     (lsu_size),
    .rf_we_i        (rf_we),
    .rd_i           (rd),
    .illegal_i      (illegal),
    .branch_i       (branch),
    .operand_a_i    (operand[0]),
    .operand_b_i    (operand[1]),
    .store_data_i   (fwd[1]),
    .bch_target_i   (bch_target),
    .pc_i           (pc_i),
    .opc_sel_i      (opc_sel),
    .ex_valid_o     (ex_valid_o),
    .ex_alu_en_o    (ex_alu_en_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_operand_c_o (ex_operand_c_o),
    .ex_lsu_en_o    (ex_lsu_en_o),
    .ex_lsu_we_o    (ex_lsu_we_o),
    .ex_lsu_sext_o  (ex_lsu_sext_o),
    .ex_lsu_size_o  (ex_lsu_size_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_rd_o        (ex_rd_o),
    .ex_illegal_o   (ex_illegal_o),
    .ex_branch_o    (ex_branch_o),
    .ex_pc_o        (ex_pc_o)
  );

endmodule

// ==== sim/tb_id_stage.sv ====
// Runs from the project root; golden rows must alternate an input line and an expected line
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

  localparam int unsigned PERIOD = 40;
  localparam int unsigned PORTS  = 2;

  logic      clk;
  logic      rst_n;
  logic      instr_valid;
  word_t     instr;
  word_t     pc;
  word_t     rf_rdata [PORTS];
  fwd_sel_e  fwd_sel [PORTS];
  word_t     rf_wdata_ex;
  word_t     rf_wdata_wb;
  logic      kill_id;
  logic      halt_id;
  logic      ex_ready;
  logic      id_ready;
  rf_addr_t  rf_raddr [PORTS];
  word_t     jmp_target;
  logic      ex_valid;
  logic      ex_alu_en;
  alu_op_e   ex_alu_op;
  word_t     ex_operand_a;
  word_t     ex_operand_b;
  word_t     ex_operand_c;
  logic      ex_lsu_en;
  logic      ex_lsu_we;
  logic      ex_lsu_sext;
  lsu_size_t ex_lsu_size;
  logic      ex_rf_we;
  rf_addr_t  ex_rd;
  logic      ex_illegal;
  logic      ex_branch;
  word_t     ex_pc;

  // Golden rows, one input line and one expected line each
  string     in_lines [$];
  string     exp_lines [$];
  int        num_rows;
  logic      rows_loaded;

  always #(PERIOD / 2) clk = ~clk;

  id_stage #(.NUM_RF_PORTS(PORTS)) u_id_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .pc_i           (pc),
    .rf_rdata_i     (rf_rdata),
    .fwd_sel_i      (fwd_sel),
    .rf_wdata_ex_i  (rf_wdata_ex),
    .rf_wdata_wb_i  (rf_wdata_wb),
    .kill_id_i      (kill_id),
    .halt_id_i      (halt_id),
    .ex_ready_i     (ex_ready),
    .id_ready_o     (id_ready),
    .rf_raddr_o     (rf_raddr),
    .jmp_target_o   (jmp_target),
    .ex_valid_o     (ex_valid),
    .ex_alu_en_o    (ex_alu_en),
    .ex_alu_op_o    (ex_alu_op),
    .ex_operand_a_o (ex_operand_a),
    .ex_operand_b_o (ex_operand_b),
    .ex_operand_c_o (ex_operand_c),
    .ex_lsu_en_o    (ex_lsu_en),
    .ex_lsu_we_o    (ex_lsu_we),
    .ex_lsu_sext_o  (ex_lsu_sext),
    .ex_lsu_size_o  (ex_lsu_size),
    .ex_rf_we_o     (ex_rf_we),
    .ex_rd_o        (ex_rd),
    .ex_illegal_o   (ex_illegal),
    .ex_branch_o    (ex_branch),
    .ex_pc_o        (ex_pc)
  );

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  // Comments and blank lines are skipped, the rest alternate input and expected
  task automatic load_golden();
    int    fd;
    int    n_read;
    string line;
    bit    want_input;
    want_input = 1'b1;
    fd = $fopen("sim/id_golden.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the golden file sim/id_golden.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n_read = $fgets(line, fd);
      if (n_read > 1 && line.getc(0) != "#") begin
        if (want_input) in_lines.push_back(line);
        else exp_lines.push_back(line);
        want_input = !want_input;
      end
    end
    $fclose(fd);
    if (in_lines.size() != exp_lines.size() || in_lines.size() == 0) begin
      abort_run("The golden file has no rows or an input line without expected line");
    end
  endtask

  // Drive one row of inputs; rnd replaces register data by random words
  task automatic drive_row(input string line);
    logic [31:0] ctl, ins, pcv, rd0, rd1, f0, f1, wex, wwb, rnd;
    if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                ctl, ins, pcv, rd0, rd1, f0, f1, wex, wwb, rnd) != 10) begin
      abort_run("Malformed input line in the golden file");
    end
    instr_valid = ctl[3];
    kill_id     = ctl[2];
    halt_id     = ctl[1];
    ex_ready    = ctl[0];
    instr       = ins;
    pc          = pcv;
    rf_rdata[0] = rnd[0] ? $urandom : rd0;
    rf_rdata[1] = rnd[0] ? $urandom : rd1;
    fwd_sel[0]  = fwd_sel_e'(f0[1:0]);
    fwd_sel[1]  = fwd_sel_e'(f1[1:0]);
    rf_wdata_ex = wex;
    rf_wdata_wb = wwb;
  endtask

  task automatic check_comb(input string line);
    logic [31:0] ra0, ra1, rdy, jc, jmp;
    if ($sscanf(line, "%h %h %h %h %h", ra0, ra1, rdy, jc, jmp) != 5) begin
      abort_run("Malformed expected line in the golden file");
    end
    check_value("rf_raddr_o[0]", 32'(rf_raddr[0]), ra0);
    check_value("rf_raddr_o[1]", 32'(rf_raddr[1]), ra1);
    check_value("id_ready_o", 32'(id_ready), rdy);
    // Target only checked on jump rows
    if (jc[0]) begin
      check_value("jmp_target_o", jmp_target, jmp);
    end
  endtask

  task automatic check_regs(input string line);
    logic [31:0] ra0, ra1, rdy, jc, jmp, flags, op, sz, rd, a, b, c, pcv;
    if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                ra0, ra1, rdy, jc, jmp, flags, op, sz, rd, a, b, c, pcv) != 13) begin
      abort_run("Malformed expected line in the golden file");
    end
    // Flag byte is valid, alu_en, lsu_en, lsu_we, sext, rf_we, illegal, branch
    check_value("ex_valid_o", 32'(ex_valid), 32'(flags[7]));
    check_value("ex_alu_en_o", 32'(ex_alu_en), 32'(flags[6]));
    check_value("ex_lsu_en_o", 32'(ex_lsu_en), 32'(flags[5]));
    check_value("ex_lsu_we_o", 32'(ex_lsu_we), 32'(flags[4]));
    check_value("ex_lsu_sext_o", 32'(ex_lsu_sext), 32'(flags[3]));
    check_value("ex_rf_we_o", 32'(ex_rf_we), 32'(flags[2]));
    check_value("ex_illegal_o", 32'(ex_illegal), 32'(flags[1]));
    check_value("ex_branch_o", 32'(ex_branch), 32'(flags[0]));
    check_value("ex_alu_op_o", 32'(ex_alu_op), op);
    check_value("ex_lsu_size_o", 32'(ex_lsu_size), sz);
    check_value("ex_rd_o", 32'(ex_rd), rd);
    check_value("ex_operand_a_o", ex_operand_a, a);
    check_value("ex_operand_b_o", ex_operand_b, b);
    check_value("ex_operand_c_o", ex_operand_c, c);
    check_value("ex_pc_o", ex_pc, pcv);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    rf_rdata[0] = '0;
    rf_rdata[1] = '0;
    fwd_sel[0]  = FWD_RF;
    fwd_sel[1]  = FWD_RF;
    rf_wdata_ex = '0;
    rf_wdata_wb = '0;
    kill_id     = 1'b0;
    halt_id     = 1'b0;
    ex_ready    = 1'b1;
    rows_loaded = 1'b0;
    void'($urandom(32'hfe84));
    load_golden();
    num_rows    = in_lines.size();
    rows_loaded = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < num_rows; i++) begin
      drive_row(in_lines[i]);
      // Just before the next edge
      #(PERIOD - 3);
      check_comb(exp_lines[i]);
      @(posedge clk);
      #2;
      check_regs(exp_lines[i]);
    end
    $display("sim passed");
    $finish;
  end

  // Watchdog sized from the row count
  initial begin
    wait (rows_loaded);
    #((num_rows + 10) * PERIOD);
    abort_run("Watchdog expired before all golden rows were checked");
  end

endmodule

// ==== sim/id_golden.txt ====
# Input line: ctl(valid,kill,halt,ex_ready) instr pc rdata0 rdata1 fwd0 fwd1 wdata_ex wdata_wb rnd
# Expected line: raddr0 raddr1 id_ready jchk jmp flags alu_op size rd op_a op_b op_c ex_pc
# ADD x3,x1,x2
9 002081B3 00000100 00000011 00000022 0 0 000000E0 000000B0 0
01 02 1 0 00000000 C4 0 0 03 00000011 00000022 00000000 00000100
# SUB x5,x6,x7 with EX on lane 0 and WB on lane 1
9 407302B3 00000104 00000066 00000077 1 2 000000E0 000000B0 0
06 07 1 0 00000000 C4 1 0 05 000000E0 000000B0 00000000 00000104
# ADDI x0,x1,-1 writes nothing
9 FFF08013 00000108 00000010 00000000 0 0 000000E0 000000B0 0
01 1F 1 0 00000000 C0 0 0 05 00000010 FFFFFFFF 00000000 00000108
# SRAI x4,x2,3
9 40315213 0000010C 80000000 00000000 0 0 000000E0 000000B0 0
02 03 1 0 00000000 C4 7 0 04 80000000 00000403 00000000 0000010C
# LUI x7,0x12345
9 123453B7 00000110 00000000 00000000 0 0 000000E0 000000B0 1
08 03 1 0 00000000 C4 0 0 07 00000000 12345000 00000000 00000110
# AUIPC x8,0x1
9 00001417 00000114 00000000 00000000 0 0 000000E0 000000B0 1
00 00 1 0 00000000 C4 0 0 08 00000114 00001000 00000000 00000114
# LW x9,8(x2)
9 00812483 00000118 00001000 00000000 0 0 000000E0 000000B0 0
02 08 1 0 00000000 EC 0 2 09 00001000 00000008 00000000 00000118
# SB x3,-4(x4) with store data from WB
9 FE320E23 0000011C 00002000 000000AB 0 2 000000E0 0000005A 0
04 03 1 0 00000000 F0 0 0 09 00002000 FFFFFFFC 0000005A 0000011C
# BNE x1,x2,-8
9 FE209CE3 00000120 00000005 00000006 0 0 000000E0 000000B0 0
01 02 1 0 00000000 D1 B 0 09 00000005 00000006 00000118 00000120
# JAL x1,+16
9 010000EF 00000124 00000000 00000000 0 0 000000E0 000000B0 1
00 10 1 1 00000134 D4 0 0 01 00000124 00000004 00000000 00000124
# JALR x5,3(x6) with base from EX
9 003302E7 00000128 00007777 00000000 1 0 00001000 000000B0 0
06 03 1 1 00001002 D4 0 0 05 00000128 00000004 00000000 00000128
# ADD held by EX stall
8 002081B3 0000012C 00000031 00000032 0 0 000000E0 000000B0 0
01 02 0 0 00000000 D4 0 0 05 00000128 00000004 00000000 00000128
# ADD accepted after stall
9 002081B3 0000012C 00000031 00000032 0 0 000000E0 000000B0 0
01 02 1 0 00000000 D4 0 0 03 00000031 00000032 00000000 0000012C
# Halt gives a bubble
B 002081B3 00000130 00000031 00000032 0 0 000000E0 000000B0 0
01 02 0 0 00000000 54 0 0 03 00000031 00000032 00000000 0000012C
# Kill gives a bubble
D 002081B3 00000130 00000031 00000032 0 0 000000E0 000000B0 0
01 02 1 0 00000000 54 0 0 03 00000031 00000032 00000000 0000012C
# ECALL is illegal
9 00000073 00000130 00000000 00000000 0 0 000000E0 000000B0 1
00 00 1 0 00000000 92 0 0 03 00000031 00000032 00000000 00000130
# Custom opcode is illegal
9 0000048B 00000134 00000000 00000000 0 0 000000E0 000000B0 1
00 00 1 0 00000000 92 0 0 03 00000031 00000032 00000000 00000134
# MUL is illegal
9 022081B3 00000138 00000031 00000032 0 0 000000E0 000000B0 0
01 02 1 0 00000000 92 0 0 03 00000031 00000032 00000000 00000138
# No valid instruction
1 00000000 0000013C 00000000 00000000 0 0 000000E0 000000B0 0
00 00 1 0 00000000 12 0 0 03 00000031 00000032 00000000 00000138

// ==== list.f ====
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_imm_target.sv
logic/id_operand_lane.sv
logic/id_ex_pipe_reg.sv
logic/id_stage.sv
sim/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_id_stage
SEED      ?= 0
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f list.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	grep -q "sim passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
